// ==== Bender.yml ====
package:
  name: soc_peripherals

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/soc_periph_pkg.sv
      - rtl/apb_if.sv
      - rtl/periph_bus_decoder.sv
      - rtl/apb_gpio.sv
      - rtl/apb_timer_unit.sv
      - rtl/soc_peripherals.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/soc_periph_assert.sv
      - verification/tb_soc_peripherals.sv

// ==== rtl/apb_gpio.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_periph_cfg.svh"

module apb_gpio
    import soc_periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    apb_if.slave      apb,
    input  gpio_vec_t gpio_in_i,
    output gpio_vec_t gpio_out_o,
    output gpio_vec_t gpio_dir_o,
    output logic      gpio_event_o
);

    logic [`SOC_PAGE_LSB-1:0] offset;
    logic                     wr_en;
    logic                     rd_en;
    logic                     status_clr;

    gpio_vec_t dir_q;
    gpio_vec_t out_q;
    gpio_vec_t inten_q;
    gpio_vec_t status_q;
    gpio_vec_t sync0_q;
    gpio_vec_t sync1_q;
    gpio_vec_t last_q;
    gpio_vec_t rise;
    logic      event_q;

    ////////////////////////////////////////////////////////////////////////////
    // register access
    ////////////////////////////////////////////////////////////////////////////

    assign offset = apb.paddr[`SOC_PAGE_LSB-1:0];
    // access cycle only, no wait states
    assign wr_en  = apb.psel & apb.penable & apb.pwrite;
    assign rd_en  = apb.psel & apb.penable & ~apb.pwrite;
    assign status_clr = rd_en & (offset == `SOC_GPIO_INTSTATUS);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dir_q   <= '0;
            out_q   <= '0;
            inten_q <= '0;
        end else if (wr_en) begin
            case (offset)
                `SOC_GPIO_DIR:   dir_q   <= apb.pwdata;
                `SOC_GPIO_OUT:   out_q   <= apb.pwdata;
                `SOC_GPIO_INTEN: inten_q <= apb.pwdata;
                // in and status are read only
                default: ;
            endcase
        end
    end

    // read data, valid during the access cycle
    always_comb begin
        case (offset)
            `SOC_GPIO_DIR:       apb.prdata = dir_q;
            `SOC_GPIO_IN:        apb.prdata = sync1_q;
            `SOC_GPIO_OUT:       apb.prdata = out_q;
            `SOC_GPIO_INTEN:     apb.prdata = inten_q;
            `SOC_GPIO_INTSTATUS: apb.prdata = status_q;
            default:             apb.prdata = '0;
        endcase
    end

    assign apb.pready  = 1'b1;
    assign apb.pslverr = 1'b0;

    ////////////////////////////////////////////////////////////////////////////
    // input sync and edge detect
    ////////////////////////////////////////////////////////////////////////////

    // two stage synchronizer, then previous level for edges
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sync0_q <= '0;
            sync1_q <= '0;
            last_q  <= '0;
        end else begin
            sync0_q <= gpio_in_i;
            sync1_q <= sync0_q;
            last_q  <= sync1_q;
        end
    end

    // rising edges on enabled pads
    assign rise = sync1_q & ~last_q & inten_q;

    // sticky status; a clearing read loses to a new edge
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            status_q <= '0;
            event_q  <= 1'b0;
        end else begin
            status_q <= (status_clr ? '0 : status_q) | rise;
            event_q  <= |rise;
        end
    end

    assign gpio_out_o   = out_q;
    assign gpio_dir_o   = dir_q;
    assign gpio_event_o = event_q;

endmodule

`default_nettype wire

// ==== rtl/apb_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface apb_if
    import soc_periph_pkg::*;
();

    // request side
    apb_addr_t paddr;
    apb_data_t pwdata;
    logic      pwrite;
    logic      psel;
    logic      penable;

    // response side
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    // decoder side toward a peripheral
    modport master (
        output paddr, pwdata, pwrite, psel, penable,
        input  prdata, pready, pslverr
    );

    // peripheral side
    modport slave (
        input  paddr, pwdata, pwrite, psel, penable,
        output prdata, pready, pslverr
    );

endinterface

`default_nettype wire

// ==== rtl/apb_timer_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_periph_cfg.svh"

module apb_timer_unit
    import soc_periph_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic slow_clk_i,
    apb_if.slave apb,
    output logic timer_event_o,
    output logic ref_clk_event_o
);

    logic [`SOC_PAGE_LSB-1:0] offset;
    logic                     wr_en;
    logic                     cnt_wr;

    logic      sclk_sync0_q;
    logic      sclk_sync1_q;
    logic      sclk_last_q;
    logic      sclk_rise;
    logic      sclk_fall;
    logic      ref_evt_q;

    logic [1:0] cfg_q;
    apb_data_t  cnt_q;
    apb_data_t  cmp_q;
    logic       tick;
    logic       count_en;
    logic       hit;
    logic       timer_evt_q;

    ////////////////////////////////////////////////////////////////////////////
    // slow clock sync and edges
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sclk_sync0_q <= 1'b0;
            sclk_sync1_q <= 1'b0;
            sclk_last_q  <= 1'b0;
            ref_evt_q    <= 1'b0;
        end else begin
            sclk_sync0_q <= slow_clk_i;
            sclk_sync1_q <= sclk_sync0_q;
            sclk_last_q  <= sclk_sync1_q;
            // one pulse per edge of either kind
            ref_evt_q    <= sclk_rise | sclk_fall;
        end
    end

    assign sclk_rise = sclk_sync1_q & ~sclk_last_q;
    assign sclk_fall = ~sclk_sync1_q & sclk_last_q;

    ////////////////////////////////////////////////////////////////////////////
    // registers and counter
    ////////////////////////////////////////////////////////////////////////////

    assign offset = apb.paddr[`SOC_PAGE_LSB-1:0];
    assign wr_en  = apb.psel & apb.penable & apb.pwrite;
    assign cnt_wr = wr_en & (offset == `SOC_TIMER_CNT);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cfg_q <= '0;
            cmp_q <= '0;
        end else if (wr_en) begin
            case (offset)
                `SOC_TIMER_CFG: cfg_q <= apb.pwdata[1:0];
                `SOC_TIMER_CMP: cmp_q <= apb.pwdata;
                default: ;
            endcase
        end
    end

    // tick source: system clock or synced slow clock rise
    assign tick     = cfg_q[`SOC_TIMER_CFG_REF] ? sclk_rise : 1'b1;
    assign count_en = cfg_q[`SOC_TIMER_CFG_EN] & tick;
    assign hit      = (cnt_q == cmp_q);

    // wrap to zero on compare, period cmp+1 ticks
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt_q       <= '0;
            timer_evt_q <= 1'b0;
        end else begin
            if (cnt_wr) begin
                cnt_q <= apb.pwdata;
            end else if (count_en) begin
                cnt_q <= hit ? '0 : cnt_q + apb_data_t'(1);
            end
            // a bus write to cnt takes priority over the wrap
            timer_evt_q <= count_en & hit & ~cnt_wr;
        end
    end

    always_comb begin
        case (offset)
            `SOC_TIMER_CFG: apb.prdata = apb_data_t'(cfg_q);
            `SOC_TIMER_CNT: apb.prdata = cnt_q;
            `SOC_TIMER_CMP: apb.prdata = cmp_q;
            default:        apb.prdata = '0;
        endcase
    end

    assign apb.pready  = 1'b1;
    assign apb.pslverr = 1'b0;

    assign timer_event_o   = timer_evt_q;
    assign ref_clk_event_o = ref_evt_q;

endmodule

`default_nettype wire

// ==== rtl/periph_bus_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_periph_cfg.svh"

module periph_bus_decoder
    import soc_periph_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,
    apb_if.slave  apb_in,
    apb_if.master gpio_bus,
    apb_if.master timer_bus
);

    apb_addr_t                              addr;
    logic [`SOC_PAGE_MSB-`SOC_PAGE_LSB:0]   page;
    logic                                   gpio_hit;
    logic                                   timer_hit;
    logic                                   gpio_hit_q;
    logic                                   timer_hit_q;

    ////////////////////////////////////////////////////////////////////////////
    // page decode
    ////////////////////////////////////////////////////////////////////////////

    assign addr      = apb_in.paddr;
    assign page      = addr[`SOC_PAGE_MSB:`SOC_PAGE_LSB];
    assign gpio_hit  = (page == `SOC_PAGE_GPIO);
    assign timer_hit = (page == `SOC_PAGE_TIMER);

    // request fields fan out to both pages
    assign gpio_bus.paddr    = addr;
    assign gpio_bus.pwdata   = apb_in.pwdata;
    assign gpio_bus.pwrite   = apb_in.pwrite;
    assign gpio_bus.penable  = apb_in.penable;
    assign timer_bus.paddr   = addr;
    assign timer_bus.pwdata  = apb_in.pwdata;
    assign timer_bus.pwrite  = apb_in.pwrite;
    assign timer_bus.penable = apb_in.penable;

    // only the addressed page sees psel
    // so an unmapped page writes nothing
    assign gpio_bus.psel  = apb_in.psel & gpio_hit;
    assign timer_bus.psel = apb_in.psel & timer_hit;

    // page held from the setup cycle
    // steers the response in the access cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            gpio_hit_q  <= 1'b0;
            timer_hit_q <= 1'b0;
        end else if (apb_in.psel && !apb_in.penable) begin
            gpio_hit_q  <= gpio_hit;
            timer_hit_q <= timer_hit;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // response mux
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (gpio_hit_q) begin
            apb_in.prdata  = gpio_bus.prdata;
            apb_in.pready  = gpio_bus.pready;
            apb_in.pslverr = gpio_bus.pslverr;
        end else if (timer_hit_q) begin
            apb_in.prdata  = timer_bus.prdata;
            apb_in.pready  = timer_bus.pready;
            apb_in.pslverr = timer_bus.pslverr;
        end else begin
            // unmapped page, answered here
            // error only in the access cycle
            apb_in.prdata  = '0;
            apb_in.pready  = 1'b1;
            apb_in.pslverr = apb_in.psel & apb_in.penable;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/soc_periph_cfg.svh ====
`ifndef SOC_PERIPH_CFG_SVH
`define SOC_PERIPH_CFG_SVH

// apb word sizes
`define SOC_APB_ADDR_WIDTH 32
`define SOC_APB_DATA_WIDTH 32

// gpio pads, one bit each in a register word
`define SOC_NGPIO 32
// lines toward the fabric controller
`define SOC_NEVENTS 32

// page field of paddr
`define SOC_PAGE_MSB 15
`define SOC_PAGE_LSB 12
`define SOC_PAGE_GPIO 4'd1
`define SOC_PAGE_TIMER 4'd11

// gpio register offsets within its page
`define SOC_GPIO_DIR 12'h000
`define SOC_GPIO_IN 12'h004
`define SOC_GPIO_OUT 12'h008
`define SOC_GPIO_INTEN 12'h00C
`define SOC_GPIO_INTSTATUS 12'h010

// timer register offsets and cfg bits
`define SOC_TIMER_CFG 12'h000
`define SOC_TIMER_CNT 12'h004
`define SOC_TIMER_CMP 12'h008
`define SOC_TIMER_CFG_EN 0
`define SOC_TIMER_CFG_REF 1

// fc event bit positions
`define SOC_EVT_DMA_PE 8
`define SOC_EVT_DMA_IRQ 9
`define SOC_EVT_TIMER_LO 10
`define SOC_EVT_PF 12
`define SOC_EVT_REF_CLK 14
`define SOC_EVT_GPIO 15

`endif

// ==== rtl/soc_periph_pkg.sv ====
`default_nettype none

`include "soc_periph_cfg.svh"

////////////////////////////////////////////////////////////////////////////
// shared types of the peripheral block
////////////////////////////////////////////////////////////////////////////

package soc_periph_pkg;

    // apb address, full byte address incl. page field
    typedef logic [`SOC_APB_ADDR_WIDTH-1:0] apb_addr_t;

    // apb data word, read and write
    typedef logic [`SOC_APB_DATA_WIDTH-1:0] apb_data_t;

    // one bit per pad
    // dir, out, in, inten and status all use this
    typedef logic [`SOC_NGPIO-1:0] gpio_vec_t;

    // event vector to the fabric controller
    // unused bits tied low at the top
    typedef logic [`SOC_NEVENTS-1:0] fc_events_t;

endpackage

`default_nettype wire

// ==== rtl/soc_peripherals.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_periph_cfg.svh"

module soc_peripherals
    import soc_periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       slow_clk_i,
    input  logic       rst_n_i,

    // apb slave port
    input  apb_addr_t  paddr_i,
    input  apb_data_t  pwdata_i,
    input  logic       pwrite_i,
    input  logic       psel_i,
    input  logic       penable_i,
    output apb_data_t  prdata_o,
    output logic       pready_o,
    output logic       pslverr_o,

    // pads
    input  gpio_vec_t  gpio_in_i,
    output gpio_vec_t  gpio_out_o,
    output gpio_vec_t  gpio_dir_o,

    // event sources from outside the block
    input  logic       dma_pe_evt_i,
    input  logic       dma_pe_irq_i,
    input  logic       pf_evt_i,
    output fc_events_t fc_events_o
);

    apb_if s_apb_bus ();
    apb_if s_gpio_bus ();
    apb_if s_timer_bus ();

    logic s_gpio_event;
    logic s_timer_event;
    logic s_ref_clk_event;

    // top level port wrapped into the upstream bus
    assign s_apb_bus.paddr   = paddr_i;
    assign s_apb_bus.pwdata  = pwdata_i;
    assign s_apb_bus.pwrite  = pwrite_i;
    assign s_apb_bus.psel    = psel_i;
    assign s_apb_bus.penable = penable_i;
    assign prdata_o  = s_apb_bus.prdata;
    assign pready_o  = s_apb_bus.pready;
    assign pslverr_o = s_apb_bus.pslverr;

    ////////////////////////////////////////////////////////////////////////////
    // bus and peripherals
    ////////////////////////////////////////////////////////////////////////////

    periph_bus_decoder i_periph_bus (
        .clk_i     ( clk_i       ),
        .rst_n_i   ( rst_n_i     ),
        .apb_in    ( s_apb_bus   ),
        .gpio_bus  ( s_gpio_bus  ),
        .timer_bus ( s_timer_bus )
    );

    apb_gpio i_apb_gpio (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .apb          ( s_gpio_bus   ),
        .gpio_in_i    ( gpio_in_i    ),
        .gpio_out_o   ( gpio_out_o   ),
        .gpio_dir_o   ( gpio_dir_o   ),
        .gpio_event_o ( s_gpio_event )
    );

    apb_timer_unit i_apb_timer_unit (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .slow_clk_i      ( slow_clk_i      ),
        .apb             ( s_timer_bus     ),
        .timer_event_o   ( s_timer_event   ),
        .ref_clk_event_o ( s_ref_clk_event )
    );

    ////////////////////////////////////////////////////////////////////////////
    // fixed fc event map
    ////////////////////////////////////////////////////////////////////////////

    // dropped sources and sw event bits stay low
    always_comb begin
        fc_events_o                    = '0;
        fc_events_o[`SOC_EVT_DMA_PE]   = dma_pe_evt_i;
        fc_events_o[`SOC_EVT_DMA_IRQ]  = dma_pe_irq_i;
        fc_events_o[`SOC_EVT_TIMER_LO] = s_timer_event;
        fc_events_o[`SOC_EVT_PF]       = pf_evt_i;
        fc_events_o[`SOC_EVT_REF_CLK]  = s_ref_clk_event;
        fc_events_o[`SOC_EVT_GPIO]     = s_gpio_event;
    end

endmodule

`default_nettype wire

// ==== verification/soc_periph_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_periph_cfg.svh"

module soc_periph_assert (
    input wire       clk_i,
    input wire       rst_n_i,
    input wire       psel,
    input wire       penable,
    input wire       pslverr,
    // timer, ref clock and gpio pulses
    input wire [2:0] pulses
);

    // number of failed assertions
    int fail_count = 0;

    ////////////////////////////////////////////////////////////////////////////
    // apb protocol
    ////////////////////////////////////////////////////////////////////////////

    // access cycle always follows a setup cycle
    penable_after_setup: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        penable |-> $past(psel && !penable))
        else begin
            $error("penable without a setup cycle");
            fail_count++;
        end

    // error response only in the access cycle
    slverr_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pslverr |-> (psel && penable))
        else begin
            $error("pslverr outside an access cycle");
            fail_count++;
        end

    ////////////////////////////////////////////////////////////////////////////
    // event pulses
    ////////////////////////////////////////////////////////////////////////////

    timer_pulse_once: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pulses[0] |=> !pulses[0])
        else begin
            $error("timer event longer than one cycle");
            fail_count++;
        end
    ref_pulse_once: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pulses[1] |=> !pulses[1])
        else begin
            $error("ref clock event longer than one cycle");
            fail_count++;
        end
    gpio_pulse_once: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pulses[2] |=> !pulses[2])
        else begin
            $error("gpio event longer than one cycle");
            fail_count++;
        end

endmodule

bind periph_bus_decoder soc_periph_assert i_dec_assert (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .psel(apb_in.psel), .penable(apb_in.penable),
    .pslverr(apb_in.pslverr), .pulses(3'b000));

bind soc_peripherals soc_periph_assert i_top_assert (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .psel(psel_i), .penable(penable_i),
    .pslverr(pslverr_o), .pulses({fc_events_o[`SOC_EVT_GPIO],
    fc_events_o[`SOC_EVT_REF_CLK], fc_events_o[`SOC_EVT_TIMER_LO]}));

`default_nettype wire

// ==== verification/tb_soc_peripherals.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_periph_cfg.svh"

module tb_soc_peripherals
    import soc_periph_pkg::*;
();

    localparam int        WAIT_LIMIT = 2000;
    localparam apb_addr_t GPIO_BASE  = {16'h0, `SOC_PAGE_GPIO, 12'h000};
    localparam apb_addr_t TIMER_BASE = {16'h0, `SOC_PAGE_TIMER, 12'h000};
    // page 3 is not mapped
    localparam apb_addr_t BAD_BASE   = 32'h0000_3000;

    logic clk_i, slow_clk_i, rst_n_i;
    apb_addr_t paddr_i;
    apb_data_t pwdata_i, prdata_o;
    logic pwrite_i, psel_i, penable_i, pready_o, pslverr_o;
    gpio_vec_t gpio_in_i, gpio_out_o, gpio_dir_o;
    logic dma_pe_evt_i, dma_pe_irq_i, pf_evt_i;
    fc_events_t fc_events_o, exp_evt;

    integer    seed = 32'h789c;
    int        errors = 0;
    int        cyc = 0;
    // expected pulse cycles per event source
    bit        exp_gpio[int];
    bit        exp_timer[int];
    bit        exp_ref[int];
    apb_data_t reg_model[apb_addr_t];
    apb_addr_t reg_addrs[8];
    bit        ref_on = 0;
    int        rises = 0;
    int        cmp_val;
    event      run_end;

    soc_peripherals UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // cycle index, bumped on every rising edge
    always @(posedge clk_i) cyc <= cyc + 1;

    ////////////////////////////////////////////////////////////////////////////
    // reference model and comparison
    ////////////////////////////////////////////////////////////////////////////

    // fixed event map, all other lines low
    function automatic fc_events_t expected_events(input logic dma_pe, input logic dma_irq,
            input logic pf, input logic timer_p, input logic ref_p, input logic gpio_p);
        fc_events_t v;
        v                    = '0;
        v[`SOC_EVT_DMA_PE]   = dma_pe;
        v[`SOC_EVT_DMA_IRQ]  = dma_irq;
        v[`SOC_EVT_TIMER_LO] = timer_p;
        v[`SOC_EVT_PF]       = pf;
        v[`SOC_EVT_REF_CLK]  = ref_p;
        v[`SOC_EVT_GPIO]     = gpio_p;
        return v;
    endfunction

    // mid cycle, all outputs settled
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            exp_evt = expected_events(dma_pe_evt_i, dma_pe_irq_i, pf_evt_i,
                exp_timer.exists(cyc), exp_ref.exists(cyc), exp_gpio.exists(cyc));
            assert (fc_events_o === exp_evt) else begin
                $display("[ERROR] fc_events_o got %h expected %h cycle %0d",
                    fc_events_o, exp_evt, cyc);
                errors++;
            end
        end
    end

    task automatic check_value(input string name, input apb_data_t got, input apb_data_t exp);
        assert (got === exp) else begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // ends the run early
    task automatic report_timeout(input string what);
        $display("timeout waiting for %s", what);
        errors++;
        -> run_end;
    endtask

    task automatic wait_until_cycle(input int target, input string what);
        int guard;
        guard = 0;
        while (cyc < target) begin
            if (guard >= WAIT_LIMIT) report_timeout(what);
            @(posedge clk_i);
            #2;
            guard++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // apb stimulus
    ////////////////////////////////////////////////////////////////////////////

    // setup then access, returns 2 ns after the closing edge
    task automatic apb_transfer(input apb_addr_t addr, input apb_data_t wdata, input logic wr,
            output apb_data_t rdata, output logic slverr);
        int guard;
        guard     = 0;
        paddr_i   = addr;
        pwdata_i  = wdata;
        pwrite_i  = wr;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        @(posedge clk_i);
        #2;
        penable_i = 1'b1;
        @(negedge clk_i);
        while (!pready_o) begin
            if (guard >= WAIT_LIMIT) report_timeout("pready");
            @(negedge clk_i);
            guard++;
        end
        rdata  = prdata_o;
        slverr = pslverr_o;
        @(posedge clk_i);
        #2;
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        apb_data_t rd;
        logic      err;
        apb_transfer(addr, data, 1'b1, rd, err);
        check_value("pslverr", apb_data_t'(err), 32'h0);
        reg_model[addr] = data;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        apb_transfer(addr, 32'h0, 1'b0, data, err);
    endtask

    // read and compare against the register model
    task automatic check_read(input apb_addr_t addr);
        apb_data_t rd;
        logic      err;
        apb_read(addr, rd, err);
        check_value("prdata", rd, reg_model[addr]);
        check_value("pslverr", apb_data_t'(err), 32'h0);
    endtask

    // ref event 3 edges after the drive, timer pulse on every cmp+1 rises
    task automatic toggle_slow_clk();
        slow_clk_i = ~slow_clk_i;
        exp_ref[cyc + 3] = 1'b1;
        if (slow_clk_i && ref_on) begin
            rises++;
            if (rises == cmp_val + 1) begin
                exp_timer[cyc + 3] = 1'b1;
                rises = 0;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        gpio_vec_t old_in, new_in, rising;
        apb_data_t rd;
        logic      err;
        int        base;
        paddr_i      = '0;
        pwdata_i     = '0;
        pwrite_i     = 1'b0;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        rst_n_i      = 1'b0;
        slow_clk_i   = 1'b0;
        gpio_in_i    = '0;
        dma_pe_evt_i = 1'b0;
        dma_pe_irq_i = 1'b0;
        pf_evt_i     = 1'b0;
        reg_addrs = '{GPIO_BASE + `SOC_GPIO_DIR, GPIO_BASE + `SOC_GPIO_IN,
            GPIO_BASE + `SOC_GPIO_OUT, GPIO_BASE + `SOC_GPIO_INTEN,
            GPIO_BASE + `SOC_GPIO_INTSTATUS, TIMER_BASE + `SOC_TIMER_CFG,
            TIMER_BASE + `SOC_TIMER_CNT, TIMER_BASE + `SOC_TIMER_CMP};
        foreach (reg_addrs[i]) reg_model[reg_addrs[i]] = '0;
        repeat (2) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;

        // reset values
        check_value("gpio_out_o", gpio_out_o, 32'h0);
        check_value("gpio_dir_o", gpio_dir_o, 32'h0);
        foreach (reg_addrs[i]) check_read(reg_addrs[i]);

        // writable registers read back
        for (int i = 0; i < 4; i++) begin
            apb_write(GPIO_BASE + `SOC_GPIO_DIR, $random(seed));
            check_value("gpio_dir_o", gpio_dir_o, reg_model[GPIO_BASE + `SOC_GPIO_DIR]);
            apb_write(GPIO_BASE + `SOC_GPIO_OUT, $random(seed));
            check_value("gpio_out_o", gpio_out_o, reg_model[GPIO_BASE + `SOC_GPIO_OUT]);
            apb_write(GPIO_BASE + `SOC_GPIO_INTEN, $random(seed));
            apb_write(TIMER_BASE + `SOC_TIMER_CMP, $random(seed));
            foreach (reg_addrs[j]) check_read(reg_addrs[j]);
        end

        // pad rises against a random enable mask
        apb_write(GPIO_BASE + `SOC_GPIO_INTEN, $random(seed));
        old_in = '0;
        for (int i = 0; i < 6; i++) begin
            new_in = $random(seed);
            rising = new_in & ~old_in & reg_model[GPIO_BASE + `SOC_GPIO_INTEN];
            gpio_in_i = new_in;
            if (|rising) exp_gpio[cyc + 3] = 1'b1;
            reg_model[GPIO_BASE + `SOC_GPIO_IN] = new_in;
            reg_model[GPIO_BASE + `SOC_GPIO_INTSTATUS] = rising;
            old_in = new_in;
            wait_until_cycle(cyc + 5, "gpio edge to settle");
            check_read(GPIO_BASE + `SOC_GPIO_IN);
            check_read(GPIO_BASE + `SOC_GPIO_INTSTATUS);
            // a status read clears the sticky bits
            reg_model[GPIO_BASE + `SOC_GPIO_INTSTATUS] = '0;
            check_read(GPIO_BASE + `SOC_GPIO_INTSTATUS);
        end

        // system clock source, period cmp+1
        cmp_val = 3 + ($random(seed) & 7);
        apb_write(TIMER_BASE + `SOC_TIMER_CMP, cmp_val);
        apb_write(TIMER_BASE + `SOC_TIMER_CFG, 32'h1);
        base = cyc;
        for (int k = 1; k <= 3; k++) exp_timer[base + k * (cmp_val + 1)] = 1'b1;
        wait_until_cycle(base + 3 * (cmp_val + 1), "timer compare pulse");
        apb_write(TIMER_BASE + `SOC_TIMER_CFG, 32'h0);
        apb_write(TIMER_BASE + `SOC_TIMER_CNT, 32'h0);

        // slow clock source, period cmp+1 rises
        cmp_val = 1 + ($random(seed) & 1);
        apb_write(TIMER_BASE + `SOC_TIMER_CMP, cmp_val);
        apb_write(TIMER_BASE + `SOC_TIMER_CFG, 32'h3);
        ref_on = 1'b1;
        rises = 0;
        for (int i = 0; i < 4 * (cmp_val + 1); i++) begin
            toggle_slow_clk();
            wait_until_cycle(cyc + 8, "slow clock period");
        end
        ref_on = 1'b0;
        apb_write(TIMER_BASE + `SOC_TIMER_CFG, 32'h0);
        check_read(TIMER_BASE + `SOC_TIMER_CNT);

        // ref events with random pass-through lines
        for (int i = 0; i < 32; i++) begin
            if (i % 8 == 0) toggle_slow_clk();
            {dma_pe_evt_i, dma_pe_irq_i, pf_evt_i} = 3'($random(seed));
            @(posedge clk_i);
            #2;
        end
        {dma_pe_evt_i, dma_pe_irq_i, pf_evt_i} = 3'b000;

        // unmapped page answers with an error
        apb_transfer(BAD_BASE + `SOC_GPIO_DIR, $random(seed), 1'b1, rd, err);
        check_value("pslverr", apb_data_t'(err), 32'h1);
        apb_read(BAD_BASE + `SOC_GPIO_DIR, rd, err);
        check_value("prdata", rd, 32'h0);
        check_value("pslverr", apb_data_t'(err), 32'h1);
        foreach (reg_addrs[i]) check_read(reg_addrs[i]);
        wait_until_cycle(cyc + 4, "final events");
        -> run_end;
    end

    initial begin
        int assert_fails;
        @(run_end);
        #1;
        // failures of the bound protocol and pulse checkers
        assert_fails = UUT.i_top_assert.fail_count + UUT.i_periph_bus.i_dec_assert.fail_count;
        $display("errors: %0d, assertion failures: %0d", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/soc_periph_pkg.sv
rtl/apb_if.sv
rtl/periph_bus_decoder.sv
rtl/apb_gpio.sv
rtl/apb_timer_unit.sv
rtl/soc_peripherals.sv
verification/soc_periph_assert.sv
verification/tb_soc_peripherals.sv
